//--- hdl/conn_mgr_params.svh
// Connection manager parameters
// Table depth and field widths shared by the RTL and the testbench

`ifndef CONN_MGR_PARAMS_SVH
`define CONN_MGR_PARAMS_SVH

// Table address bits, 2**CM_ADDR_WIDTH entries
`define CM_ADDR_WIDTH     4

// Connection id as seen on every port
`define CM_CONN_ID_WIDTH  32

// Destination address fields
`define CM_IP_WIDTH       32
`define CM_PORT_WIDTH     16

// RPC payload, carried through untouched
`define CM_PAYLOAD_WIDTH  64

`endif

//--- hdl/conn_mgr_pkg.sv
// Connection manager package
// Encodings for connection status, command opcode and the result code
// returned for each open/close command

`include "conn_mgr_params.svh"

package conn_mgr_pkg;

    // Status bit stored in every table entry, closed after the sweep
    typedef enum logic {
        CONN_CLOSED = 1'b0,
        CONN_OPEN   = 1'b1
    } conn_status_e;

    typedef enum logic {
        OP_CLOSE = 1'b0,
        OP_OPEN  = 1'b1
    } cm_op_e;

    // Result code reported on the status channel
    typedef enum logic [1:0] {
        ERR_OK           = 2'd0,
        ERR_ID_WRONG     = 2'd1,
        ERR_ALREADY_OPEN = 2'd2,
        ERR_IS_CLOSED    = 2'd3
    } cm_err_e;

endpackage

//--- hdl/conn_table.sv
// Connection table
// Register array of connection entries (status, destination IP and port).
// A pulse on initialize starts a sweep that clears one entry per cycle.
// Two read ports with registered outputs: control and RPC lookup.

`timescale 1ns/1ps
`include "conn_mgr_params.svh"

module conn_table (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        initialize,
    output logic                        initialized,
    input  logic                        wr_en,
    input  logic [`CM_ADDR_WIDTH-1:0]   wr_addr,
    input  conn_mgr_pkg::conn_status_e  wr_status,
    input  logic [`CM_IP_WIDTH-1:0]     wr_dest_ip,
    input  logic [`CM_PORT_WIDTH-1:0]   wr_dest_port,
    input  logic [`CM_ADDR_WIDTH-1:0]   ctl_rd_addr,
    output conn_mgr_pkg::conn_status_e  ctl_rd_status,
    input  logic [`CM_ADDR_WIDTH-1:0]   lk_rd_addr,
    output conn_mgr_pkg::conn_status_e  lk_rd_status,
    output logic [`CM_IP_WIDTH-1:0]     lk_rd_dest_ip,
    output logic [`CM_PORT_WIDTH-1:0]   lk_rd_dest_port
);
    import conn_mgr_pkg::*;

    conn_status_e               status_mem [2**`CM_ADDR_WIDTH];
    logic [`CM_IP_WIDTH-1:0]    ip_mem     [2**`CM_ADDR_WIDTH];
    logic [`CM_PORT_WIDTH-1:0]  port_mem   [2**`CM_ADDR_WIDTH];

    logic                       sweeping;
    logic [`CM_ADDR_WIDTH-1:0]  sweep_addr;

    logic                       mem_we;
    logic [`CM_ADDR_WIDTH-1:0]  mem_addr;
    conn_status_e               mem_status;
    logic [`CM_IP_WIDTH-1:0]    mem_ip;
    logic [`CM_PORT_WIDTH-1:0]  mem_port;

    // ======================================================================
    // Clearing sweep
    // ======================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            sweeping    <= 1'b0;
            sweep_addr  <= '0;
            initialized <= 1'b0;
        end else if (sweeping) begin
            // Address wraps back to zero after the last entry
            sweep_addr <= sweep_addr + 1'b1;
            if (&sweep_addr) begin
                sweeping    <= 1'b0;
                initialized <= 1'b1;
            end
        end else if (initialize) begin
            sweeping    <= 1'b1;
            initialized <= 1'b0;
        end
    end

    // Sweep overrides the command write port
    always_comb begin
        if (sweeping) begin
            mem_we     = 1'b1;
            mem_addr   = sweep_addr;
            mem_status = CONN_CLOSED;
            mem_ip     = '0;
            mem_port   = '0;
        end else begin
            mem_we     = wr_en;
            mem_addr   = wr_addr;
            mem_status = wr_status;
            mem_ip     = wr_dest_ip;
            mem_port   = wr_dest_port;
        end
    end

    // ======================================================================
    // Storage and read ports
    // ======================================================================
    // Reads see the entry as it was before a write on the same edge
    always_ff @(posedge clk) begin
        if (mem_we) begin
            status_mem[mem_addr] <= mem_status;
            ip_mem[mem_addr]     <= mem_ip;
            port_mem[mem_addr]   <= mem_port;
        end
        ctl_rd_status   <= status_mem[ctl_rd_addr];
        lk_rd_status    <= status_mem[lk_rd_addr];
        lk_rd_dest_ip   <= ip_mem[lk_rd_addr];
        lk_rd_dest_port <= port_mem[lk_rd_addr];
    end

    // Execute may only write once the table is cleared
    a_no_write_in_sweep: assert property (
        @(posedge clk) disable iff (reset) sweeping |-> !wr_en);

endmodule

//--- hdl/conn_cmd_decode.sv
// Command decoder
// Accepts open/close commands once the table is initialized, holds one
// decoded command for the execute stage and flags out-of-range ids

`timescale 1ns/1ps
`include "conn_mgr_params.svh"

module conn_cmd_decode (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          initialized,
    input  logic                          cmd_valid,
    output logic                          cmd_ready,
    input  logic                          cmd_open,
    input  logic [`CM_CONN_ID_WIDTH-1:0]  cmd_conn_id,
    input  logic [`CM_IP_WIDTH-1:0]       cmd_dest_ip,
    input  logic [`CM_PORT_WIDTH-1:0]     cmd_dest_port,
    output logic                          op_valid,
    input  logic                          op_ready,
    output conn_mgr_pkg::cm_op_e          op_code,
    output logic [`CM_ADDR_WIDTH-1:0]     op_addr,
    output logic                          op_id_wrong,
    output logic [`CM_CONN_ID_WIDTH-1:0]  op_conn_id,
    output logic [`CM_IP_WIDTH-1:0]       op_dest_ip,
    output logic [`CM_PORT_WIDTH-1:0]     op_dest_port
);
    import conn_mgr_pkg::*;

    logic cmd_accept;

    // One command at a time, nothing before the sweep is done
    assign cmd_ready  = initialized && !op_valid;
    assign cmd_accept = cmd_valid && cmd_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            op_valid <= 1'b0;
        end else if (cmd_accept) begin
            op_valid <= 1'b1;
        end else if (op_ready) begin
            op_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_accept) begin
            op_code      <= cmd_open ? OP_OPEN : OP_CLOSE;
            op_addr      <= cmd_conn_id[`CM_ADDR_WIDTH-1:0];
            // Any bit above the address range makes the id invalid
            op_id_wrong  <= |cmd_conn_id[`CM_CONN_ID_WIDTH-1:`CM_ADDR_WIDTH];
            op_conn_id   <= cmd_conn_id;
            op_dest_ip   <= cmd_dest_ip;
            op_dest_port <= cmd_dest_port;
        end
    end

    a_op_hold: assert property (
        @(posedge clk) disable iff (reset)
        op_valid && !op_ready |=> op_valid && $stable({op_code, op_addr, op_id_wrong,
                                                       op_conn_id, op_dest_ip, op_dest_port}));

endmodule

//--- hdl/conn_ctl_execute.sv
// Connection control execute stage
// Reads the current status of the addressed entry, decides whether the
// open or close is legal, writes the table and reports a result code

`timescale 1ns/1ps
`include "conn_mgr_params.svh"

module conn_ctl_execute (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          op_valid,
    output logic                          op_ready,
    input  conn_mgr_pkg::cm_op_e          op_code,
    input  logic [`CM_ADDR_WIDTH-1:0]     op_addr,
    input  logic                          op_id_wrong,
    input  logic [`CM_CONN_ID_WIDTH-1:0]  op_conn_id,
    input  logic [`CM_IP_WIDTH-1:0]       op_dest_ip,
    input  logic [`CM_PORT_WIDTH-1:0]     op_dest_port,
    output logic [`CM_ADDR_WIDTH-1:0]     ctl_rd_addr,
    input  conn_mgr_pkg::conn_status_e    ctl_rd_status,
    output logic                          wr_en,
    output logic [`CM_ADDR_WIDTH-1:0]     wr_addr,
    output conn_mgr_pkg::conn_status_e    wr_status,
    output logic [`CM_IP_WIDTH-1:0]       wr_dest_ip,
    output logic [`CM_PORT_WIDTH-1:0]     wr_dest_port,
    output logic                          res_valid,
    input  logic                          res_ready,
    output logic [`CM_CONN_ID_WIDTH-1:0]  res_conn_id,
    output conn_mgr_pkg::cm_err_e         res_err
);
    import conn_mgr_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_CHECK, ST_REPORT} exec_state_e;

    exec_state_e                state;
    cm_op_e                     code_q;
    logic [`CM_IP_WIDTH-1:0]    ip_q;
    logic [`CM_PORT_WIDTH-1:0]  port_q;
    logic                       is_open;
    logic                       legal;

    assign op_ready  = (state == ST_IDLE);
    assign res_valid = (state == ST_REPORT);

    // Table samples the address on the accept edge
    assign ctl_rd_addr = op_addr;

    // Open needs a closed entry, close needs an open one
    assign is_open = (code_q == OP_OPEN);
    assign legal   = is_open ? (ctl_rd_status == CONN_CLOSED) : (ctl_rd_status == CONN_OPEN);

    // Write on the edge that enters the report state
    assign wr_en        = (state == ST_CHECK) && legal;
    assign wr_status    = is_open ? CONN_OPEN : CONN_CLOSED;
    assign wr_dest_ip   = is_open ? ip_q : '0;
    assign wr_dest_port = is_open ? port_q : '0;

    // ======================================================================
    // Control FSM
    // ======================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (op_valid) begin
                        state <= op_id_wrong ? ST_REPORT : ST_CHECK;
                    end
                end
                ST_CHECK: state <= ST_REPORT;
                default: begin
                    if (res_ready) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Held operation and result code
    always_ff @(posedge clk) begin
        if (op_valid && op_ready) begin
            code_q      <= op_code;
            wr_addr     <= op_addr;
            res_conn_id <= op_conn_id;
            ip_q        <= op_dest_ip;
            port_q      <= op_dest_port;
            res_err     <= ERR_ID_WRONG;
        end else if (state == ST_CHECK) begin
            if (legal) begin
                res_err <= ERR_OK;
            end else begin
                res_err <= is_open ? ERR_ALREADY_OPEN : ERR_IS_CLOSED;
            end
        end
    end

    a_write_then_report: assert property (
        @(posedge clk) disable iff (reset) wr_en |=> state == ST_REPORT && res_err == ERR_OK);

endmodule

//--- hdl/conn_status_result.sv
// Status result register
// Single-entry buffer between execute and the status consumer, holds
// one result until status_ready is seen

`timescale 1ns/1ps
`include "conn_mgr_params.svh"

module conn_status_result (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          res_valid,
    output logic                          res_ready,
    input  logic [`CM_CONN_ID_WIDTH-1:0]  res_conn_id,
    input  conn_mgr_pkg::cm_err_e         res_err,
    output logic                          status_valid,
    input  logic                          status_ready,
    output logic [`CM_CONN_ID_WIDTH-1:0]  status_conn_id,
    output conn_mgr_pkg::cm_err_e         status_err
);
    import conn_mgr_pkg::*;

    cm_err_e err_q;

    assign res_ready  = !status_valid;
    assign status_err = err_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            status_valid <= 1'b0;
        end else if (res_valid && res_ready) begin
            status_valid <= 1'b1;
        end else if (status_ready) begin
            status_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid && res_ready) begin
            status_conn_id <= res_conn_id;
            err_q          <= res_err;
        end
    end

    a_status_hold: assert property (
        @(posedge clk) disable iff (reset)
        status_valid && !status_ready |=> status_valid && $stable({status_conn_id, err_q}));

endmodule

//--- hdl/rpc_lookup_path.sv
// Outbound RPC lookup path
// Two-stage pipeline: stage 1 range-checks the connection id and starts
// the table lookup, stage 2 attaches the destination address and drops
// RPCs to closed connections. Any drop sets a sticky error flag

`timescale 1ns/1ps
`include "conn_mgr_params.svh"

module rpc_lookup_path (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          rpc_in_valid,
    input  logic [`CM_CONN_ID_WIDTH-1:0]  rpc_in_conn_id,
    input  logic [`CM_PAYLOAD_WIDTH-1:0]  rpc_in_payload,
    output logic [`CM_ADDR_WIDTH-1:0]     lk_rd_addr,
    input  conn_mgr_pkg::conn_status_e    lk_rd_status,
    input  logic [`CM_IP_WIDTH-1:0]       lk_rd_dest_ip,
    input  logic [`CM_PORT_WIDTH-1:0]     lk_rd_dest_port,
    output logic                          rpc_out_valid,
    output logic [`CM_CONN_ID_WIDTH-1:0]  rpc_out_conn_id,
    output logic [`CM_PAYLOAD_WIDTH-1:0]  rpc_out_payload,
    output logic [`CM_IP_WIDTH-1:0]       rpc_out_dest_ip,
    output logic [`CM_PORT_WIDTH-1:0]     rpc_out_dest_port,
    output logic                          error
);
    import conn_mgr_pkg::*;

    logic                           in_range;
    logic                           s1_valid;
    logic [`CM_CONN_ID_WIDTH-1:0]   s1_conn_id;
    logic [`CM_PAYLOAD_WIDTH-1:0]   s1_payload;
    logic                           s2_open;

    // Stage 1
    assign in_range   = ~|rpc_in_conn_id[`CM_CONN_ID_WIDTH-1:`CM_ADDR_WIDTH];
    assign lk_rd_addr = rpc_in_conn_id[`CM_ADDR_WIDTH-1:0];

    // Stage 2, lookup result lines up with the stage 1 registers
    assign s2_open = (lk_rd_status == CONN_OPEN);

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid      <= 1'b0;
            rpc_out_valid <= 1'b0;
            error         <= 1'b0;
        end else begin
            s1_valid      <= rpc_in_valid && in_range;
            rpc_out_valid <= s1_valid && s2_open;
            if ((rpc_in_valid && !in_range) || (s1_valid && !s2_open)) begin
                error <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        s1_conn_id        <= rpc_in_conn_id;
        s1_payload        <= rpc_in_payload;
        rpc_out_conn_id   <= s1_conn_id;
        rpc_out_payload   <= s1_payload;
        rpc_out_dest_ip   <= lk_rd_dest_ip;
        rpc_out_dest_port <= lk_rd_dest_port;
    end

endmodule

//--- hdl/conn_manager_top.sv
// Connection manager top level
// Connection table with command decode, execute and status result on
// the control side, and the outbound RPC lookup path

`timescale 1ns/1ps
`include "conn_mgr_params.svh"

module conn_manager_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          initialize,
    output logic                          initialized,
    input  logic                          cmd_valid,
    output logic                          cmd_ready,
    input  logic                          cmd_open,
    input  logic [`CM_CONN_ID_WIDTH-1:0]  cmd_conn_id,
    input  logic [`CM_IP_WIDTH-1:0]       cmd_dest_ip,
    input  logic [`CM_PORT_WIDTH-1:0]     cmd_dest_port,
    output logic                          status_valid,
    input  logic                          status_ready,
    output logic [`CM_CONN_ID_WIDTH-1:0]  status_conn_id,
    output conn_mgr_pkg::cm_err_e         status_err,
    input  logic                          rpc_in_valid,
    input  logic [`CM_CONN_ID_WIDTH-1:0]  rpc_in_conn_id,
    input  logic [`CM_PAYLOAD_WIDTH-1:0]  rpc_in_payload,
    output logic                          rpc_out_valid,
    output logic [`CM_CONN_ID_WIDTH-1:0]  rpc_out_conn_id,
    output logic [`CM_PAYLOAD_WIDTH-1:0]  rpc_out_payload,
    output logic [`CM_IP_WIDTH-1:0]       rpc_out_dest_ip,
    output logic [`CM_PORT_WIDTH-1:0]     rpc_out_dest_port,
    output logic                          error
);

    // Decode to execute
    logic                          op_valid;
    logic                          op_ready;
    conn_mgr_pkg::cm_op_e          op_code;
    logic [`CM_ADDR_WIDTH-1:0]     op_addr;
    logic                          op_id_wrong;
    logic [`CM_CONN_ID_WIDTH-1:0]  op_conn_id;
    logic [`CM_IP_WIDTH-1:0]       op_dest_ip;
    logic [`CM_PORT_WIDTH-1:0]     op_dest_port;

    // Table ports
    logic [`CM_ADDR_WIDTH-1:0]     ctl_rd_addr;
    conn_mgr_pkg::conn_status_e    ctl_rd_status;
    logic                          wr_en;
    logic [`CM_ADDR_WIDTH-1:0]     wr_addr;
    conn_mgr_pkg::conn_status_e    wr_status;
    logic [`CM_IP_WIDTH-1:0]       wr_dest_ip;
    logic [`CM_PORT_WIDTH-1:0]     wr_dest_port;
    logic [`CM_ADDR_WIDTH-1:0]     lk_rd_addr;
    conn_mgr_pkg::conn_status_e    lk_rd_status;
    logic [`CM_IP_WIDTH-1:0]       lk_rd_dest_ip;
    logic [`CM_PORT_WIDTH-1:0]     lk_rd_dest_port;

    // Execute to result
    logic                          res_valid;
    logic                          res_ready;
    logic [`CM_CONN_ID_WIDTH-1:0]  res_conn_id;
    conn_mgr_pkg::cm_err_e         res_err;

    conn_table i_table (.*);

    conn_cmd_decode i_decode (.*);

    conn_ctl_execute i_execute (.*);

    conn_status_result i_result (.*);

    rpc_lookup_path i_rpc (.*);

endmodule

//--- dv/conn_manager_tb.sv
// Connection manager testbench
// Drives open/close commands and outbound RPCs into the connection manager,
// keeps a reference copy of the connection table and compares status
// results, forwarded RPCs and the sticky error flag against it

`timescale 1ns/1ps
`include "conn_mgr_params.svh"

module conn_manager_tb;
    import conn_mgr_pkg::*;

    localparam int DEPTH      = 2**`CM_ADDR_WIDTH;
    localparam int WAIT_LIMIT = 200;

    typedef struct packed {
        logic [`CM_CONN_ID_WIDTH-1:0] conn_id;
        cm_err_e                      err;
    } status_exp_t;

    typedef struct packed {
        logic                         fwd;
        logic                         oor;
        logic                         closed_drop;
        logic [`CM_CONN_ID_WIDTH-1:0] conn_id;
        logic [`CM_PAYLOAD_WIDTH-1:0] payload;
        logic [`CM_IP_WIDTH-1:0]      ip;
        logic [`CM_PORT_WIDTH-1:0]    port;
    } rpc_exp_t;

    logic                          clk;
    logic                          reset;
    logic                          initialize;
    logic                          initialized;
    logic                          cmd_valid;
    logic                          cmd_ready;
    logic                          cmd_open;
    logic [`CM_CONN_ID_WIDTH-1:0]  cmd_conn_id;
    logic [`CM_IP_WIDTH-1:0]       cmd_dest_ip;
    logic [`CM_PORT_WIDTH-1:0]     cmd_dest_port;
    logic                          status_valid;
    logic                          status_ready;
    logic [`CM_CONN_ID_WIDTH-1:0]  status_conn_id;
    cm_err_e                       status_err;
    logic                          rpc_in_valid;
    logic [`CM_CONN_ID_WIDTH-1:0]  rpc_in_conn_id;
    logic [`CM_PAYLOAD_WIDTH-1:0]  rpc_in_payload;
    logic                          rpc_out_valid;
    logic [`CM_CONN_ID_WIDTH-1:0]  rpc_out_conn_id;
    logic [`CM_PAYLOAD_WIDTH-1:0]  rpc_out_payload;
    logic [`CM_IP_WIDTH-1:0]       rpc_out_dest_ip;
    logic [`CM_PORT_WIDTH-1:0]     rpc_out_dest_port;
    logic                          error;

    // Reference table
    logic                          model_open [DEPTH];
    logic [`CM_IP_WIDTH-1:0]       model_ip   [DEPTH];
    logic [`CM_PORT_WIDTH-1:0]     model_port [DEPTH];

    status_exp_t                   exp_status_q [$];
    status_exp_t                   held_val;
    rpc_exp_t                      pipe1;
    rpc_exp_t                      pipe2;
    logic                          held;
    logic                          err_exp;
    integer                        seed;
    int                            mismatch_count;
    int                            failure_count;
    logic                          stall_on;
    logic [7:0]                    stall_idx;
    bit                            stall_pattern [256];

    conn_manager_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("MISMATCH time=%0t signal=%s got=%0h expected=%0h", $time, name, got, exp);
        mismatch_count++;
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR time=%0t %s", $time, msg);
        failure_count++;
    endtask

    // ======================================================================
    // Reference model
    // ======================================================================
    function automatic cm_err_e expected_err(input logic open,
                                             input logic [`CM_CONN_ID_WIDTH-1:0] id);
        logic [`CM_ADDR_WIDTH-1:0] a;
        a = id[`CM_ADDR_WIDTH-1:0];
        if (id >= DEPTH) return ERR_ID_WRONG;
        if (open) return model_open[a] ? ERR_ALREADY_OPEN : ERR_OK;
        return model_open[a] ? ERR_OK : ERR_IS_CLOSED;
    endfunction

    function automatic rpc_exp_t rpc_expect(input logic valid,
                                            input logic [`CM_CONN_ID_WIDTH-1:0] id,
                                            input logic [`CM_PAYLOAD_WIDTH-1:0] payload);
        rpc_exp_t e;
        logic [`CM_ADDR_WIDTH-1:0] a;
        a = id[`CM_ADDR_WIDTH-1:0];
        e.oor         = valid && (id >= DEPTH);
        e.fwd         = valid && !e.oor && model_open[a];
        e.closed_drop = valid && !e.oor && !model_open[a];
        e.conn_id     = id;
        e.payload     = payload;
        e.ip          = model_ip[a];
        e.port        = model_port[a];
        return e;
    endfunction

    function automatic logic [`CM_CONN_ID_WIDTH-1:0] pick_open_id(input logic [31:0] r);
        logic [`CM_ADDR_WIDTH-1:0] a;
        a = r[`CM_ADDR_WIDTH-1:0];
        for (int k = 0; k < DEPTH; k++) begin
            if (model_open[a]) return `CM_CONN_ID_WIDTH'(a);
            a = a + 1'b1;
        end
        return `CM_CONN_ID_WIDTH'(a);
    endfunction

    // ======================================================================
    // Comparison, sampled mid-cycle
    // ======================================================================
    always @(negedge clk) begin
        status_exp_t exp;
        if (reset) begin
            pipe1   = '0;
            pipe2   = '0;
            err_exp = 1'b0;
            held    = 1'b0;
        end else begin
            assert (rpc_out_valid == pipe2.fwd)
                else report_mismatch("rpc_out_valid", 64'(rpc_out_valid), 64'(pipe2.fwd));
            if (rpc_out_valid && pipe2.fwd) begin
                assert (rpc_out_conn_id == pipe2.conn_id)
                    else report_mismatch("rpc_out_conn_id", 64'(rpc_out_conn_id),
                                         64'(pipe2.conn_id));
                assert (rpc_out_payload == pipe2.payload)
                    else report_mismatch("rpc_out_payload", rpc_out_payload, pipe2.payload);
                assert (rpc_out_dest_ip == pipe2.ip)
                    else report_mismatch("rpc_out_dest_ip", 64'(rpc_out_dest_ip), 64'(pipe2.ip));
                assert (rpc_out_dest_port == pipe2.port)
                    else report_mismatch("rpc_out_dest_port", 64'(rpc_out_dest_port),
                                         64'(pipe2.port));
            end
            // Range drops flag one cycle after input, closed drops two
            err_exp = err_exp | pipe1.oor | pipe2.closed_drop;
            assert (error == err_exp) else report_mismatch("error", 64'(error), 64'(err_exp));
            pipe2 = pipe1;
            pipe1 = rpc_expect(rpc_in_valid, rpc_in_conn_id, rpc_in_payload);

            if (held) begin
                assert (status_valid && status_conn_id == held_val.conn_id
                        && status_err == held_val.err)
                    else report_failure("status changed or vanished before it was taken");
            end
            if (status_valid && status_ready) begin
                if (exp_status_q.size() == 0) begin
                    report_failure("status result with no command outstanding");
                end else begin
                    exp = exp_status_q.pop_front();
                    assert (status_conn_id == exp.conn_id)
                        else report_mismatch("status_conn_id", 64'(status_conn_id),
                                             64'(exp.conn_id));
                    assert (status_err == exp.err)
                        else report_mismatch("status_err", 64'(status_err), 64'(exp.err));
                end
            end
            held             = status_valid && !status_ready;
            held_val.conn_id = status_conn_id;
            held_val.err     = status_err;
        end
    end

    // Consumer ready, random stretches while stalling
    always @(posedge clk) begin
        if (stall_on) begin
            status_ready <= stall_pattern[stall_idx];
            stall_idx    <= stall_idx + 8'd1;
        end else begin
            status_ready <= 1'b1;
        end
    end

    // ======================================================================
    // Stimulus tasks
    // ======================================================================
    task automatic build_stall_pattern();
        int idx;
        int run;
        bit level;
        idx   = 0;
        level = 1'b0;
        while (idx < 256) begin
            run = 1 + int'(($random(seed) & 32'h7fff_ffff) % 6);
            for (int k = 0; k < run && idx < 256; k++) begin
                stall_pattern[idx] = level;
                idx++;
            end
            level = !level;
        end
    endtask

    task automatic run_init();
        int waited;
        @(posedge clk);
        initialize <= 1'b1;
        @(posedge clk);
        initialize <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!initialized && waited < DEPTH + 4) begin
            assert (!cmd_ready) else report_failure("cmd_ready high before initialized");
            @(negedge clk);
            waited++;
        end
        if (!initialized) report_failure("timeout waiting for initialized after the sweep");
        for (int i = 0; i < DEPTH; i++) begin
            model_open[i] = 1'b0;
            model_ip[i]   = '0;
            model_port[i] = '0;
        end
    endtask

    task automatic send_command(input logic open, input logic [`CM_CONN_ID_WIDTH-1:0] id,
                                input logic [`CM_IP_WIDTH-1:0] ip,
                                input logic [`CM_PORT_WIDTH-1:0] port);
        status_exp_t exp;
        logic [`CM_ADDR_WIDTH-1:0] a;
        int waited;
        a           = id[`CM_ADDR_WIDTH-1:0];
        exp.conn_id = id;
        exp.err     = expected_err(open, id);
        if (exp.err == ERR_OK) begin
            model_open[a] = open;
            model_ip[a]   = open ? ip : '0;
            model_port[a] = open ? port : '0;
        end
        exp_status_q.push_back(exp);
        @(posedge clk);
        cmd_valid     <= 1'b1;
        cmd_open      <= open;
        cmd_conn_id   <= id;
        cmd_dest_ip   <= ip;
        cmd_dest_port <= port;
        waited = 0;
        @(negedge clk);
        while (!cmd_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!cmd_ready) report_failure("timeout waiting for cmd_ready");
        @(posedge clk);
        cmd_valid <= 1'b0;
    endtask

    task automatic wait_status_drain();
        int waited;
        waited = 0;
        while (exp_status_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_status_q.size() != 0) report_failure("timeout waiting for status results");
        @(posedge clk);
    endtask

    task automatic rpc_burst(input int count, input bit allow_bad);
        logic [31:0] r;
        for (int n = 0; n < count; n++) begin
            r = $random(seed);
            @(posedge clk);
            rpc_in_valid   <= (r[31:30] != 2'b00);
            rpc_in_conn_id <= allow_bad ? {27'd0, r[4:0]} : pick_open_id(r);
            rpc_in_payload <= {$random(seed), $random(seed)};
        end
        @(posedge clk);
        rpc_in_valid <= 1'b0;
        // Pipeline depth is fixed at two stages
        repeat (3) @(posedge clk);
    endtask

    task automatic random_commands(input int count);
        logic [31:0] r;
        for (int n = 0; n < count; n++) begin
            r = $random(seed);
            send_command(r[8], 32'(r[7:0] % 20), $random(seed), r[31:16]);
        end
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        seed           = 32'h1945c485;
        reset          = 1'b1;
        initialize     = 1'b0;
        cmd_valid      = 1'b0;
        cmd_open       = 1'b0;
        cmd_conn_id    = '0;
        cmd_dest_ip    = '0;
        cmd_dest_port  = '0;
        status_ready   = 1'b0;
        rpc_in_valid   = 1'b0;
        rpc_in_conn_id = '0;
        rpc_in_payload = '0;
        stall_on       = 1'b0;
        stall_idx      = '0;
        mismatch_count = 0;
        failure_count  = 0;
        build_stall_pattern();
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (!cmd_ready && !status_valid && !rpc_out_valid && !initialized && !error)
            else report_failure("outputs not low after reset");
        run_init();

        // Open/close sequence on one id
        send_command(1'b1, 32'd5, 32'h0a00_0005, 16'd5005);
        send_command(1'b1, 32'd5, 32'h0a00_0006, 16'd5006);
        send_command(1'b0, 32'd5, '0, '0);
        send_command(1'b0, 32'd5, '0, '0);
        wait_status_drain();

        send_command(1'b1, 32'd1, 32'hc0a8_0001, 16'd80);
        send_command(1'b1, 32'd3, 32'hc0a8_0003, 16'd443);
        send_command(1'b1, 32'd7, 32'hc0a8_0007, 16'd8080);
        // Out of range, low bits alias open entries
        send_command(1'b0, 32'h13, '0, '0);
        send_command(1'b1, 32'h8000_0007, 32'hdead_beef, 16'd1);
        wait_status_drain();
        random_commands(8);
        wait_status_drain();
        rpc_burst(40, 1'b0);

        stall_on <= 1'b1;
        random_commands(12);
        wait_status_drain();
        stall_on <= 1'b0;

        send_command(1'b1, 32'd2, 32'hc0a8_0002, 16'd22);
        wait_status_drain();
        rpc_burst(40, 1'b1);
        assert (error) else report_failure("error flag not set by dropped RPCs");
        assert (exp_status_q.size() == 0) else report_failure("status results missing at end");

        $display("Error counts: %0d mismatches, %0d other failures",
                 mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+hdl
hdl/conn_mgr_pkg.sv
hdl/conn_table.sv
hdl/conn_cmd_decode.sv
hdl/conn_ctl_execute.sv
hdl/conn_status_result.sv
hdl/rpc_lookup_path.sv
hdl/conn_manager_top.sv
dv/conn_manager_tb.sv

//--- Makefile
# Verilator build, run and lint for the connection manager

VERILATOR ?= verilator
TOP       ?= conn_manager_tb
LINT_TOP  ?= conn_manager_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv hdl/*.svh dv/*.sv)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TB FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
